//--- hw/hdc_pkg.sv
package hdc_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // hypervector dimension, one 32-bit word
    localparam int HV_W        = 32;
    // item memory entries and address width
    localparam int ITEM_DEPTH  = 16;
    localparam int ITEM_ADDR_W = 4;
    // one core instruction per 16-bit slice of the input word
    localparam int INSTR_W     = 16;
    localparam int NUM_CORES   = 2;
    // signed bundle counter per dimension
    localparam int CNT_W       = 8;

    // --------------------------------------------------
    // xorshift32
    // --------------------------------------------------

    localparam logic [31:0] XS_SEED = 32'h2545F491;
    // left, right, left
    localparam int XS_SHIFT_A = 13;
    localparam int XS_SHIFT_B = 17;
    localparam int XS_SHIFT_C = 5;

    // --------------------------------------------------
    // types
    // --------------------------------------------------

    typedef logic [HV_W-1:0]        hv_t;
    typedef logic [ITEM_ADDR_W-1:0] item_addr_t;

    // instruction bits 15..14, item index in bits 3..0
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_BIND  = 2'd2,
        OP_STORE = 2'd3
    } opcode_t;

endpackage

//--- hw/item_fill_if.sv
`timescale 1ns/1ps

// item memory write bus, generator to every core
interface item_fill_if;

    // one write per strobe cycle, no handshake
    logic                 wr_en;
    hdc_pkg::item_addr_t  wr_addr;
    hdc_pkg::hv_t         wr_data;
    // high for the whole fill
    logic                 filling;

    modport source (
        output wr_en, wr_addr, wr_data, filling
    );

    modport sink (
        input wr_en, wr_addr, wr_data, filling
    );

endinterface

//--- hw/item_generator.sv
`timescale 1ns/1ps

module item_generator (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        gen_start,
    input  logic [4:0]  item_count,
    output logic        gen_done,
    item_fill_if.source fill
);

    // one xorshift32 step
    function automatic hdc_pkg::hv_t xs_step(input hdc_pkg::hv_t s);
        hdc_pkg::hv_t x;
        x = s ^ (s << hdc_pkg::XS_SHIFT_A);
        x = x ^ (x >> hdc_pkg::XS_SHIFT_B);
        x = x ^ (x << hdc_pkg::XS_SHIFT_C);
        return x;
    endfunction

    // current random word, always the value being written
    hdc_pkg::hv_t        xs_q;
    // address of the final entry of this fill
    hdc_pkg::item_addr_t last_addr;

    // --------------------------------------------------
    // fill control
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            fill.wr_en   <= 1'b0;
            fill.filling <= 1'b0;
            gen_done     <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            // a new start restarts the fill from entry 0
            if (gen_start) begin
                fill.wr_en   <= 1'b1;
                fill.filling <= 1'b1;
            end else if (fill.wr_en && fill.wr_addr == last_addr) begin
                // last entry lands on this edge
                fill.wr_en   <= 1'b0;
                fill.filling <= 1'b0;
                gen_done     <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // random word and write address
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (gen_start) begin
            // seed reloads, entry 0 gets the first step
            xs_q         <= xs_step(hdc_pkg::XS_SEED);
            fill.wr_addr <= '0;
            last_addr    <= hdc_pkg::item_addr_t'(item_count - 5'd1);
        end else if (fill.wr_en) begin
            xs_q         <= xs_step(xs_q);
            fill.wr_addr <= fill.wr_addr + 1'b1;
        end
    end

    assign fill.wr_data = xs_q;

    // count must fit the item memory
    a_item_count : assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_start |-> (item_count >= 5'd1 && item_count <= hdc_pkg::ITEM_DEPTH)
    ) else $error("item_count out of range at gen_start");

endmodule

//--- hw/encoder_core.sv
`timescale 1ns/1ps

module encoder_core (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    item_fill_if.sink                   fill,
    input  logic                        in_valid,
    input  logic [hdc_pkg::INSTR_W-1:0] instr,
    input  logic                        in_last,
    output logic                        store_valid,
    output hdc_pkg::hv_t                store_hv,
    output logic                        store_last
);

    // item memory, written only by the generator
    hdc_pkg::hv_t mem [hdc_pkg::ITEM_DEPTH];

    // accepted beat, none while a fill runs
    logic beat;

    // stage 1 registers
    logic             valid_q;
    logic             last_q;
    hdc_pkg::opcode_t op_q;
    hdc_pkg::hv_t     item_q;

    // running hypervector
    hdc_pkg::hv_t acc;

    // --------------------------------------------------
    // item memory
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (fill.wr_en) begin
            mem[fill.wr_addr] <= fill.wr_data;
        end
    end

    // one cycle read latency, index straight from the instruction
    always_ff @(posedge AXIS_ACLK) begin
        item_q <= mem[instr[hdc_pkg::ITEM_ADDR_W-1:0]];
    end

    // --------------------------------------------------
    // stage 1: decode
    // --------------------------------------------------

    assign beat = in_valid && !fill.filling;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            op_q    <= hdc_pkg::OP_NOP;
        end else begin
            valid_q <= beat;
            // last travels even with no store on this core
            last_q  <= beat && in_last;
            // opcode in the top two bits
            op_q    <= hdc_pkg::opcode_t'(instr[hdc_pkg::INSTR_W-1 -: 2]);
        end
    end

    // --------------------------------------------------
    // stage 2: accumulator
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            acc         <= '0;
            store_valid <= 1'b0;
            store_last  <= 1'b0;
        end else begin
            store_valid <= 1'b0;
            store_last  <= last_q;
            if (valid_q) begin
                unique case (op_q)
                    hdc_pkg::OP_NOP: begin
                    end
                    hdc_pkg::OP_LOAD: begin
                        acc <= item_q;
                    end
                    hdc_pkg::OP_BIND: begin
                        // rotate left by one, then xor in the item
                        acc <= {acc[hdc_pkg::HV_W-2:0], acc[hdc_pkg::HV_W-1]} ^ item_q;
                    end
                    hdc_pkg::OP_STORE: begin
                        store_valid <= 1'b1;
                        acc         <= '0;
                    end
                endcase
            end
        end
    end

    // stored value goes out with the strobe
    always_ff @(posedge AXIS_ACLK) begin
        if (valid_q && op_q == hdc_pkg::OP_STORE) begin
            store_hv <= acc;
        end
    end

    // a refill under a live beat would change the item it reads
    a_no_fill_mid_beat : assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        fill.wr_en |-> !valid_q
    ) else $error("item memory written while a beat is decoded");

endmodule

//--- hw/bundler.sv
`timescale 1ns/1ps

module bundler (
    input  logic                          AXIS_ACLK,
    input  logic                          S_AXI_ARESETN,
    input  logic [hdc_pkg::NUM_CORES-1:0] store_valid,
    input  hdc_pkg::hv_t                  store_hv [hdc_pkg::NUM_CORES],
    input  logic [hdc_pkg::NUM_CORES-1:0] store_last,
    output logic                          out_valid,
    output hdc_pkg::hv_t                  out_data
);

    // one signed counter per dimension
    logic signed [hdc_pkg::CNT_W-1:0] cnt [hdc_pkg::HV_W];
    // next count, two bits of headroom for the range check
    logic signed [hdc_pkg::CNT_W+1:0] sum [hdc_pkg::HV_W];
    // bundle closes on the next edge
    logic last_q;

    // --------------------------------------------------
    // per-dimension add
    // --------------------------------------------------

    always_comb begin
        for (int d = 0; d < hdc_pkg::HV_W; d++) begin
            // closing edge starts from zero
            if (last_q) begin
                sum[d] = '0;
            end else begin
                sum[d] = cnt[d];
            end
            // +1 for a one, -1 for a zero, per storing core
            for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
                if (store_valid[c]) begin
                    if (store_hv[c][d]) begin
                        sum[d] = sum[d] + 1;
                    end else begin
                        sum[d] = sum[d] - 1;
                    end
                end
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            for (int d = 0; d < hdc_pkg::HV_W; d++) begin
                cnt[d] <= '0;
            end
            last_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            for (int d = 0; d < hdc_pkg::HV_W; d++) begin
                cnt[d] <= sum[d][hdc_pkg::CNT_W-1:0];
            end
            // either core's flag closes the bundle
            last_q    <= |store_last;
            out_valid <= last_q;
        end
    end

    // --------------------------------------------------
    // sign vector
    // --------------------------------------------------

    // tie gives 0
    always_ff @(posedge AXIS_ACLK) begin
        if (last_q) begin
            for (int d = 0; d < hdc_pkg::HV_W; d++) begin
                out_data[d] <= (cnt[d] > 0);
            end
        end
    end

    for (genvar d = 0; d < hdc_pkg::HV_W; d++) begin : g_range
        a_cnt_range : assert property (
            @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
            (sum[d] >= -(2 ** (hdc_pkg::CNT_W - 1))) &&
            (sum[d] < (2 ** (hdc_pkg::CNT_W - 1)))
        ) else $error("bundle counter overflow");
    end

endmodule

//--- hw/hdc_encoder_top.sv
`timescale 1ns/1ps

module hdc_encoder_top (
    input  logic         AXIS_ACLK,
    input  logic         S_AXI_ARESETN,
    // item memory fill
    input  logic         gen_start,
    input  logic [4:0]   item_count,
    output logic         gen_done,
    // instruction beats, one 16-bit slice per core
    input  logic         in_valid,
    input  logic [31:0]  in_data,
    input  logic         in_last,
    // bundled sign vector
    output logic         out_valid,
    output hdc_pkg::hv_t out_data
);

    // --------------------------------------------------
    // item memory fill
    // --------------------------------------------------

    // shared by the generator and all cores
    item_fill_if fill_bus ();

    item_generator gen_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_start     (gen_start),
        .item_count    (item_count),
        .gen_done      (gen_done),
        .fill          (fill_bus)
    );

    // --------------------------------------------------
    // encoding cores
    // --------------------------------------------------

    // core stores toward the bundler
    logic [hdc_pkg::NUM_CORES-1:0] store_valid;
    logic [hdc_pkg::NUM_CORES-1:0] store_last;
    hdc_pkg::hv_t                  store_hv [hdc_pkg::NUM_CORES];

    // core c takes bits 16c+15 .. 16c
    for (genvar c = 0; c < hdc_pkg::NUM_CORES; c++) begin : g_core
        encoder_core core_i (
            .AXIS_ACLK     (AXIS_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .fill          (fill_bus),
            .in_valid      (in_valid),
            .instr         (in_data[c*hdc_pkg::INSTR_W +: hdc_pkg::INSTR_W]),
            .in_last       (in_last),
            .store_valid   (store_valid[c]),
            .store_hv      (store_hv[c]),
            .store_last    (store_last[c])
        );
    end

    // --------------------------------------------------
    // bundling
    // --------------------------------------------------

    // sign vector two edges after the final store
    bundler bundler_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .store_valid   (store_valid),
        .store_hv      (store_hv),
        .store_last    (store_last),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

//--- test/hdc_encoder_tb.sv
`timescale 1ns/1ps

module hdc_encoder_tb;

    // longest run of all tests is a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;
    // beat sampled to out_valid sampled
    localparam int OUT_LATENCY    = 4;

    logic         clk;
    logic         rstn;
    logic         gen_start;
    logic [4:0]   item_count;
    logic         gen_done;
    logic         in_valid;
    logic [31:0]  in_data;
    logic         in_last;
    logic         out_valid;
    hdc_pkg::hv_t out_data;

    // number of rising edges seen so far
    int     cyc;
    integer seed;

    // reference model state
    hdc_pkg::hv_t items_m [hdc_pkg::ITEM_DEPTH];
    hdc_pkg::hv_t acc_m   [hdc_pkg::NUM_CORES];
    int           cnt_m   [hdc_pkg::HV_W];

    // expected bundles and the edge of their last beat
    hdc_pkg::hv_t exp_data  [$];
    int           exp_edge  [$];
    // strobes seen on the DUT outputs
    hdc_pkg::hv_t got_data  [$];
    int           got_edge  [$];
    int           done_edge [$];

    hdc_encoder_top dut_i (
        .AXIS_ACLK     (clk),
        .S_AXI_ARESETN (rstn),
        .gen_start     (gen_start),
        .item_count    (item_count),
        .gen_done      (gen_done),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_last       (in_last),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not respond within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // sample outputs at the falling edge and tag them with the edge that samples them
    always @(negedge clk) begin
        if (out_valid) begin
            got_data.push_back(out_data);
            got_edge.push_back(cyc + 1);
        end
        if (gen_done) begin
            done_edge.push_back(cyc + 1);
        end
    end

    // --------------------------------------------------
    // reporting and model
    // --------------------------------------------------

    task automatic report_value(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected 0x%h actual 0x%h", name, what, exp, act);
        $display(">>> FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic hdc_pkg::hv_t xorshift32(input hdc_pkg::hv_t s);
        hdc_pkg::hv_t x;
        x = s;
        x = x ^ (x << hdc_pkg::XS_SHIFT_A);
        x = x ^ (x >> hdc_pkg::XS_SHIFT_B);
        x = x ^ (x << hdc_pkg::XS_SHIFT_C);
        return x;
    endfunction

    function automatic logic [15:0] make_instr(input hdc_pkg::opcode_t op, input int idx);
        return {op, 10'd0, idx[3:0]};
    endfunction

    // entry k gets step k+1 as the seed reloads on each fill
    task automatic model_fill(input int n);
        hdc_pkg::hv_t x;
        x = hdc_pkg::XS_SEED;
        for (int k = 0; k < n; k++) begin
            x = xorshift32(x);
            items_m[k] = x;
        end
    endtask

    task automatic model_beat(input logic [15:0] i0, input logic [15:0] i1,
                              input logic last, input int at_edge);
        logic [15:0]  ins;
        hdc_pkg::hv_t word;
        for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
            ins  = (c == 0) ? i0 : i1;
            word = items_m[ins[3:0]];
            case (hdc_pkg::opcode_t'(ins[15:14]))
                hdc_pkg::OP_LOAD: acc_m[c] = word;
                hdc_pkg::OP_BIND: acc_m[c] = {acc_m[c][30:0], acc_m[c][31]} ^ word;
                hdc_pkg::OP_STORE: begin
                    // +1 per one bit and -1 per zero bit
                    for (int d = 0; d < hdc_pkg::HV_W; d++) begin
                        cnt_m[d] += acc_m[c][d] ? 1 : -1;
                    end
                    acc_m[c] = '0;
                end
                default: begin
                end
            endcase
        end
        if (last) begin
            // sign vector where a tie gives 0
            for (int d = 0; d < hdc_pkg::HV_W; d++) begin
                word[d]  = (cnt_m[d] > 0);
                cnt_m[d] = 0;
            end
            exp_data.push_back(word);
            exp_edge.push_back(at_edge);
        end
    endtask

    // --------------------------------------------------
    // driving and checking
    // --------------------------------------------------

    // next drive point 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_beat(input logic [15:0] i0, input logic [15:0] i1, input logic last);
        in_valid = 1'b1;
        in_data  = {i1, i0};
        in_last  = last;
        model_beat(i0, i1, last, cyc + 1);
        step_cycle();
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic run_fill(input string name, input int n);
        int start_edge;
        gen_start  = 1'b1;
        item_count = 5'(n);
        start_edge = cyc + 1;
        model_fill(n);
        step_cycle();
        gen_start = 1'b0;
        while (done_edge.size() == 0) begin
            step_cycle();
        end
        // a strobe longer than one cycle would show up here
        step_cycle();
        assert (done_edge.size() == 1)
            else report_value(name, "gen_done strobes", 1, done_edge.size());
        assert (done_edge[0] == start_edge + n + 1)
            else report_value(name, "gen_done latency", n + 1, done_edge[0] - start_edge);
        done_edge.delete();
    endtask

    task automatic check_outputs(input string name);
        while (got_data.size() < exp_data.size()) begin
            step_cycle();
        end
        step_cycle();
        assert (got_data.size() == exp_data.size())
            else report_value(name, "out_valid strobes", exp_data.size(), got_data.size());
        foreach (exp_data[i]) begin
            assert (got_data[i] == exp_data[i])
                else report_value(name, $sformatf("bundle %0d out_data", i),
                                  exp_data[i], got_data[i]);
            assert (got_edge[i] == exp_edge[i] + OUT_LATENCY)
                else report_value(name, $sformatf("bundle %0d latency", i),
                                  OUT_LATENCY, got_edge[i] - exp_edge[i]);
        end
        exp_data.delete();
        exp_edge.delete();
        got_data.delete();
        got_edge.delete();
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------

    task automatic test_reset_state();
        assert (gen_done === 1'b0 && out_valid === 1'b0 && dut_i.fill_bus.filling === 1'b0)
            else report_failure("gen_done, out_valid or filling is not low after reset");
    endtask

    // full fill with every entry read back and then a short refill from the same seed
    task automatic test_fill();
        run_fill("fill", hdc_pkg::ITEM_DEPTH);
        for (int k = 0; k < hdc_pkg::ITEM_DEPTH; k++) begin
            send_beat(make_instr(hdc_pkg::OP_LOAD, k), make_instr(hdc_pkg::OP_NOP, 0), 1'b0);
            send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_NOP, 0), 1'b1);
        end
        check_outputs("fill");
        run_fill("refill", 5);
    endtask

    task automatic test_single_item();
        send_beat(make_instr(hdc_pkg::OP_LOAD, 5), make_instr(hdc_pkg::OP_NOP, 0), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_NOP, 0), 1'b1);
        check_outputs("single_item");
    endtask

    // with two stores the ties make it the AND of both bound vectors
    task automatic test_binding();
        send_beat(make_instr(hdc_pkg::OP_LOAD, 1), make_instr(hdc_pkg::OP_LOAD, 7), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_BIND, 2), make_instr(hdc_pkg::OP_BIND, 9), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_BIND, 3), make_instr(hdc_pkg::OP_BIND, 11), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_STORE, 0), 1'b1);
        check_outputs("binding");
    endtask

    // three stores on core 0 and two on core 1
    task automatic test_majority();
        send_beat(make_instr(hdc_pkg::OP_LOAD, 2), make_instr(hdc_pkg::OP_LOAD, 4), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_STORE, 0), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_LOAD, 10), make_instr(hdc_pkg::OP_LOAD, 12), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_STORE, 0), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_LOAD, 14), make_instr(hdc_pkg::OP_NOP, 0), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_NOP, 0), 1'b1);
        check_outputs("majority");
    endtask

    // second bundle stores on the beat right after the first one closes
    task automatic test_pipelined();
        send_beat(make_instr(hdc_pkg::OP_LOAD, 3), make_instr(hdc_pkg::OP_LOAD, 5), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_LOAD, 6), 1'b1);
        send_beat(make_instr(hdc_pkg::OP_LOAD, 8), make_instr(hdc_pkg::OP_STORE, 0), 1'b0);
        send_beat(make_instr(hdc_pkg::OP_STORE, 0), make_instr(hdc_pkg::OP_NOP, 0), 1'b1);
        check_outputs("pipelined");
    endtask

    // 1 to 8 beats per bundle and so at most 16 stores
    task automatic test_random();
        int          n;
        logic [15:0] i0;
        logic [15:0] i1;
        for (int b = 0; b < 20; b++) begin
            n = ($random(seed) & 7) + 1;
            for (int k = 0; k < n; k++) begin
                i0 = 16'($random(seed));
                i1 = 16'($random(seed));
                send_beat(i0, i1, k == n - 1);
            end
        end
        check_outputs("random");
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        gen_start  = 1'b0;
        item_count = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_last    = 1'b0;
        cyc        = 0;
        seed       = 74;
        for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
            acc_m[c] = '0;
        end
        for (int d = 0; d < hdc_pkg::HV_W; d++) begin
            cnt_m[d] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_reset_state();
        test_fill();
        test_single_item();
        test_binding();
        test_majority();
        test_pipelined();
        test_random();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
hw/hdc_pkg.sv
hw/item_fill_if.sv
hw/item_generator.sv
hw/encoder_core.sv
hw/bundler.sv
hw/hdc_encoder_top.sv
test/hdc_encoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdc_encoder_tb \
    -f verilog.f \
    -o hdc_encoder_sim

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/hdc_encoder_sim
